//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/100ps --top-module tb_axi_wr_master -f sim.f
	@out=$$(./obj_dir/Vtb_axi_wr_master); echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

//--- apb_wr_regs.sv
// APB slave with no wait states; STATUS is read-only, start is dropped while a write is in flight
`timescale 1ns/100ps

module apb_wr_regs (
    input  logic                             clock,
    input  logic                             rst_n,

    // APB slave
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [axi_wr_pkg::apb_addr_w-1:0] paddr,
    input  logic [axi_wr_pkg::data_w-1:0]    pwdata,
    output logic [axi_wr_pkg::data_w-1:0]    prdata,
    output logic                             pready,
    output logic                             pslverr,

    // Command toward the channels
    output axi_wr_pkg::wr_cmd_t              cmd,
    output logic                             start,
    input  logic                             req_busy,
    input  logic                             resp_busy,

    // Response from the response channel
    input  logic                             sys_valid,
    input  axi_wr_pkg::bresp_t               sys_resp,
    output logic                             sys_ready
);

    import axi_wr_pkg::*;

    logic [addr_w-1:0]  addr_q;
    logic [data_w-1:0]  data_q;
    logic [strb_w-1:0]  strb_q;

    logic               done_q;
    bresp_t             bresp_q;
    logic [count_w-1:0] count_q;

    wr_status_t         status;
    logic [data_w-1:0]  status_word;

    logic               access;
    logic               wr_en;
    logic               mapped;
    logic               busy;
    logic               start_req;

    // --------------------
    // APB decode

    // Access phase is the second cycle of a transfer
    assign access  = psel & penable;
    assign wr_en   = access & pwrite;
    assign mapped  = (paddr == reg_addr) || (paddr == reg_data) ||
                     (paddr == reg_ctrl) || (paddr == reg_status);
    assign pready  = 1'b1;
    assign pslverr = access & ~mapped;

    // A write in flight on either channel blocks a new start
    assign busy      = req_busy | resp_busy;
    assign start_req = wr_en & (paddr == reg_ctrl) & pwdata[0] & ~busy;

    // The response is always taken as soon as it shows up
    assign sys_ready = sys_valid;

    // --------------------
    // Register writes

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            addr_q  <= '0;
            data_q  <= '0;
            strb_q  <= '0;
            start   <= 1'b0;
            done_q  <= 1'b0;
            bresp_q <= okay;
            count_q <= '0;
        end else begin
            if (wr_en && paddr == reg_addr) begin
                addr_q <= pwdata;
            end
            if (wr_en && paddr == reg_data) begin
                data_q <= pwdata;
            end
            if (wr_en && paddr == reg_ctrl) begin
                strb_q <= pwdata[7:4];
            end

            // Start is a one-cycle pulse after the accepted CTRL write
            start <= start_req;

            // Done is sticky until the next start is accepted
            if (start_req) begin
                done_q <= 1'b0;
            end else if (sys_valid && sys_ready) begin
                done_q  <= 1'b1;
                bresp_q <= sys_resp;
                count_q <= count_q + 1'b1;
            end
        end
    end

    assign cmd.addr = addr_q;
    assign cmd.data = data_q;
    assign cmd.strb = strb_q;

    // --------------------
    // Read data

    // busy is live so software never sees a stale idle state
    assign status.busy  = busy;
    assign status.done  = done_q;
    assign status.bresp = bresp_q;
    assign status.count = count_q;

    assign status_word = {{(data_w - 16){1'b0}}, status.count, 4'b0000,
                          status.bresp, status.done, status.busy};

    always_comb begin
        case (paddr)
            reg_addr:   prdata = addr_q;
            reg_data:   prdata = data_q;
            // Start bit is write-only and reads back as zero
            reg_ctrl:   prdata = {{(data_w - 8){1'b0}}, strb_q, 4'b0000};
            reg_status: prdata = status_word;
            default:    prdata = '0;
        endcase
    end

endmodule

//--- axi_wr_checker.sv
// Watches the DUT ports and compares them with a model; assumes software waits for idle before each start
`timescale 1ns/100ps

module axi_wr_checker (
    input  logic                              clock,
    input  logic                              rst_n,

    // APB side as seen at the DUT
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [axi_wr_pkg::apb_addr_w-1:0] paddr,
    input  logic [axi_wr_pkg::data_w-1:0]     pwdata,
    input  logic [axi_wr_pkg::data_w-1:0]     prdata,
    input  logic                              pslverr,

    // AXI side as seen at the DUT
    input  axi_wr_pkg::axi_aw_t               aw,
    input  logic                              awvalid,
    input  logic                              awready,
    input  axi_wr_pkg::axi_w_t                w,
    input  logic                              wvalid,
    input  logic                              wready,
    input  axi_wr_pkg::bresp_t                bresp,
    input  logic                              bvalid,
    input  logic                              bready,

    // Test bookkeeping from the testbench top
    input  logic                              test_end,
    input  int                                test_num,
    output int                                tests_run,
    output int                                tests_failed,
    output int                                errors
);

    import axi_wr_pkg::*;

    // Register model, the command caught at start and the status fields
    wr_cmd_t    m_regs;
    wr_cmd_t    m_cmd;
    wr_status_t m_stat;

    // Channel model, each flag tracks the matching DUT signal cycle by cycle
    logic       start_d;
    logic       start_next;
    logic       aw_pend;
    logic       w_pend;
    logic       armed;
    logic       b_seen;
    bresp_t     last_bresp;
    logic       mapped;

    // Handshake totals against accepted starts
    int         starts;
    int         aw_hs;
    int         w_hs;
    int         b_hs;
    int         test_errs;

    function automatic string test_name(input int n);
        case (n)
            1:       return "reset_values";
            2:       return "register_readback";
            3:       return "single_write";
            4:       return "stalled_writes";
            5:       return "start_while_busy";
            6:       return "unmapped_access";
            default: return "no_test";
        endcase
    endfunction

    // Read data as the register map defines it
    function automatic logic [data_w-1:0] expected_read(input logic [apb_addr_w-1:0] a);
        case (a)
            reg_addr: return m_regs.addr;
            reg_data: return m_regs.data;
            reg_ctrl: return {24'h0, m_regs.strb, 4'h0};
            default:  return {16'h0, m_stat.count, 4'h0, m_stat.bresp, m_stat.done, m_stat.busy};
        endcase
    endfunction

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR %s %s: expected %h, actual %h", test_name(test_num), what, exp, act);
            errors++;
            test_errs++;
        end
    endtask

    always @(posedge clock) begin
        if (!rst_n) begin
            m_regs       = '0;
            m_cmd        = '0;
            m_stat       = '0;
            start_d      = 1'b0;
            aw_pend      = 1'b0;
            w_pend       = 1'b0;
            armed        = 1'b0;
            b_seen       = 1'b0;
            last_bresp   = okay;
            starts       = 0;
            aw_hs        = 0;
            w_hs         = 0;
            b_hs         = 0;
            test_errs    = 0;
            tests_run    = 0;
            tests_failed = 0;
            errors       = 0;
        end else begin
            // --------------------
            // AXI outputs against the channel model
            compare("awvalid", 32'(aw_pend), 32'(awvalid));
            compare("wvalid", 32'(w_pend), 32'(wvalid));
            if (!armed) begin
                compare("bready while idle", 32'(1'b0), 32'(bready));
            end
            if (awvalid) begin
                compare("awaddr", m_cmd.addr, aw.awaddr);
            end
            if (wvalid) begin
                compare("wdata", m_cmd.data, w.wdata);
                compare("wstrb", 32'(m_cmd.strb), 32'(w.wstrb));
                compare("wlast", 32'(1'b1), 32'(w.wlast));
            end

            // --------------------
            // APB access phase, checked before the model moves on
            start_next = 1'b0;
            if (psel && penable) begin
                mapped = paddr inside {reg_addr, reg_data, reg_ctrl, reg_status};
                compare("pslverr", 32'(!mapped), 32'(pslverr));
                if (!pwrite && mapped) begin
                    compare($sformatf("read of offset %h", paddr), expected_read(paddr), prdata);
                end
                if (pwrite && paddr == reg_addr) begin
                    m_regs.addr = pwdata;
                end
                if (pwrite && paddr == reg_data) begin
                    m_regs.data = pwdata;
                end
                if (pwrite && paddr == reg_ctrl) begin
                    m_regs.strb = pwdata[7:4];
                    // The command carries the strobe written in this same access
                    if (pwdata[0] && !m_stat.busy) begin
                        m_cmd       = m_regs;
                        m_stat.busy = 1'b1;
                        m_stat.done = 1'b0;
                        start_next  = 1'b1;
                        starts++;
                    end
                end
            end

            // --------------------
            // Handshakes and the response path
            if (awvalid && awready) begin
                aw_hs++;
                aw_pend = 1'b0;
            end
            if (wvalid && wready) begin
                w_hs++;
                w_pend = 1'b0;
            end
            // A response is consumed one edge after its B handshake
            if (b_seen) begin
                m_stat.busy  = 1'b0;
                m_stat.done  = 1'b1;
                m_stat.bresp = last_bresp;
                m_stat.count = m_stat.count + 8'd1;
                armed        = 1'b0;
                b_seen       = 1'b0;
            end
            if (bvalid && bready) begin
                b_hs++;
                last_bresp = bresp;
                b_seen     = 1'b1;
            end
            // Channels wake up one edge after the start pulse is issued
            if (start_d) begin
                aw_pend = 1'b1;
                w_pend  = 1'b1;
                armed   = 1'b1;
            end
            start_d = start_next;

            if (test_end) begin
                compare("AW handshakes", 32'(starts), 32'(aw_hs));
                compare("W handshakes", 32'(starts), 32'(w_hs));
                compare("B handshakes", 32'(starts), 32'(b_hs));
                tests_run++;
                if (test_errs == 0) begin
                    $display("PASS %s", test_name(test_num));
                end else begin
                    tests_failed++;
                    $display("FAIL %s with %0d errors", test_name(test_num), test_errs);
                end
                test_errs = 0;
            end
        end
    end

endmodule

//--- axi_wr_master.sv
// Single-beat AXI4 write master under APB control; one write in flight, no IDs or bursts
`timescale 1ns/100ps

module axi_wr_master (
    input  logic                             clock,
    input  logic                             rst_n,

    // APB slave
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [axi_wr_pkg::apb_addr_w-1:0] paddr,
    input  logic [axi_wr_pkg::data_w-1:0]    pwdata,
    output logic [axi_wr_pkg::data_w-1:0]    prdata,
    output logic                             pready,
    output logic                             pslverr,

    // AXI write address channel
    output axi_wr_pkg::axi_aw_t              aw,
    output logic                             awvalid,
    input  logic                             awready,

    // AXI write data channel
    output axi_wr_pkg::axi_w_t               w,
    output logic                             wvalid,
    input  logic                             wready,

    // AXI write response channel
    input  axi_wr_pkg::bresp_t               bresp,
    input  logic                             bvalid,
    output logic                             bready
);

    import axi_wr_pkg::*;

    // --------------------
    // Internal nets

    wr_cmd_t cmd;
    logic    start;
    logic    req_busy;
    logic    resp_busy;
    logic    sys_valid;
    logic    sys_ready;
    bresp_t  sys_resp;

    // Register block owns the command and gathers the status
    apb_wr_regs u_regs (
        .clock     (clock),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .cmd       (cmd),
        .start     (start),
        .req_busy  (req_busy),
        .resp_busy (resp_busy),
        .sys_valid (sys_valid),
        .sys_resp  (sys_resp),
        .sys_ready (sys_ready)
    );

    // AW and W share the start pulse but finish on their own
    axi_wr_request_channel u_req (
        .clock    (clock),
        .rst_n    (rst_n),
        .start    (start),
        .cmd      (cmd),
        .aw       (aw),
        .awvalid  (awvalid),
        .awready  (awready),
        .w        (w),
        .wvalid   (wvalid),
        .wready   (wready),
        .req_busy (req_busy)
    );

    // The same start arms the B receiver
    axi_wr_response_channel u_resp (
        .clock     (clock),
        .rst_n     (rst_n),
        .start     (start),
        .resp_busy (resp_busy),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .sys_valid (sys_valid),
        .sys_ready (sys_ready),
        .sys_resp  (sys_resp)
    );

endmodule

//--- axi_wr_pkg.sv
// Shared widths, APB offsets and AXI channel types; AXI widths are fixed here for a 32-bit bus
package axi_wr_pkg;

    // --------------------
    // Bus widths

    localparam int addr_w     = 32;
    localparam int data_w     = 32;
    localparam int strb_w     = data_w / 8;
    localparam int bresp_w    = 2;
    localparam int count_w    = 8;
    localparam int apb_addr_w = 4;

    // --------------------
    // APB register offsets, byte addressed

    localparam logic [apb_addr_w-1:0] reg_addr   = 4'h0;
    localparam logic [apb_addr_w-1:0] reg_data   = 4'h4;
    localparam logic [apb_addr_w-1:0] reg_ctrl   = 4'h8;
    localparam logic [apb_addr_w-1:0] reg_status = 4'hC;

    // AXI4 write response codes, in the order the spec encodes them
    typedef enum logic [bresp_w-1:0] {
        okay   = 2'b00,
        exokay = 2'b01,
        slverr = 2'b10,
        decerr = 2'b11
    } bresp_t;

    // --------------------
    // Channel payloads

    // One write command as programmed over APB
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
    } wr_cmd_t;

    typedef struct packed {
        logic [addr_w-1:0] awaddr;
    } axi_aw_t;

    typedef struct packed {
        logic [data_w-1:0] wdata;
        logic [strb_w-1:0] wstrb;
        logic              wlast;
    } axi_w_t;

    // Fields of the STATUS register before they are packed into the APB word
    typedef struct packed {
        logic               busy;
        logic               done;
        bresp_t             bresp;
        logic [count_w-1:0] count;
    } wr_status_t;

endpackage

//--- axi_wr_request_channel.sv
// Single-beat AW and W driver; a start while a beat is still pending is assumed not to happen
`timescale 1ns/100ps

module axi_wr_request_channel (
    input  logic                 clock,
    input  logic                 rst_n,

    // Command from the register block
    input  logic                 start,
    input  axi_wr_pkg::wr_cmd_t  cmd,

    // AXI write address channel
    output axi_wr_pkg::axi_aw_t  aw,
    output logic                 awvalid,
    input  logic                 awready,

    // AXI write data channel
    output axi_wr_pkg::axi_w_t   w,
    output logic                 wvalid,
    input  logic                 wready,

    output logic                 req_busy
);

    import axi_wr_pkg::*;

    // Copy of the command taken at start, so APB writes during the
    // transfer cannot disturb the values on the bus
    wr_cmd_t cmd_q;

    // One pending flag per channel, since AW and W complete independently
    logic    aw_pend;
    logic    w_pend;

    logic    aw_fire;
    logic    w_fire;

    // --------------------
    // Handshakes

    assign aw_fire = aw_pend & awready;
    assign w_fire  = w_pend & wready;

    // --------------------
    // Pending flags

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            aw_pend <= 1'b0;
            w_pend  <= 1'b0;
        end else begin
            // Start sets both, each handshake clears only its own flag
            if (start) begin
                aw_pend <= 1'b1;
            end else if (aw_fire) begin
                aw_pend <= 1'b0;
            end

            if (start) begin
                w_pend <= 1'b1;
            end else if (w_fire) begin
                w_pend <= 1'b0;
            end
        end
    end

    // Command latch carries no reset because it is only seen while a valid is high
    always_ff @(posedge clock) begin
        if (start) begin
            cmd_q <= cmd;
        end
    end

    // --------------------
    // Channel outputs

    // Valids come from flops so they rise the cycle after start
    assign awvalid  = aw_pend;
    assign wvalid   = w_pend;

    assign aw.awaddr = cmd_q.addr;

    assign w.wdata  = cmd_q.data;
    assign w.wstrb  = cmd_q.strb;
    // Every transfer is one beat, so the only beat is also the last
    assign w.wlast  = 1'b1;

    // Busy until both channels have handed off their beat
    assign req_busy = aw_pend | w_pend;

endmodule

//--- axi_wr_response_channel.sv
// Armed B-channel receiver; exactly one response is handed to the system side per start
`timescale 1ns/100ps

module axi_wr_response_channel (
    input  logic                clock,
    input  logic                rst_n,

    // Control side
    input  logic                start,
    output logic                resp_busy,

    // AXI write response channel
    input  axi_wr_pkg::bresp_t  bresp,
    input  logic                bvalid,
    output logic                bready,

    // System side
    output logic                sys_valid,
    input  logic                sys_ready,
    output axi_wr_pkg::bresp_t  sys_resp
);

    import axi_wr_pkg::*;

    // Set by start, held until the system side takes one response
    logic               armed;

    // Skid buffer ports, before gating by the armed flag
    logic               buf_s_valid;
    logic               buf_s_ready;
    logic               buf_m_valid;
    logic               buf_m_ready;
    logic [bresp_w-1:0] buf_m_data;

    logic               consume;

    // --------------------
    // Gating toward AXI and toward the system

    // While idle both sides of the buffer look disconnected, so a stray
    // bvalid is neither accepted nor passed on
    assign buf_s_valid = bvalid & armed;
    assign bready      = buf_s_ready & armed;

    assign sys_valid   = buf_m_valid & armed;
    assign buf_m_ready = sys_ready & armed;

    assign sys_resp    = bresp_t'(buf_m_data);

    skid_buffer #(
        .word_width (bresp_w)
    ) u_resp_buf (
        .clock      (clock),
        .rst_n      (rst_n),
        .s_valid    (buf_s_valid),
        .s_ready    (buf_s_ready),
        .s_data     (bresp),
        .m_valid    (buf_m_valid),
        .m_ready    (buf_m_ready),
        .m_data     (buf_m_data)
    );

    // --------------------
    // Transaction state

    // One response read out on the system side ends the transaction
    assign consume = sys_valid & sys_ready;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            armed <= 1'b0;
        end else if (start) begin
            armed <= 1'b1;
        end else if (consume) begin
            armed <= 1'b0;
        end
    end

    assign resp_busy = armed;

endmodule

//--- sim.f
axi_wr_pkg.sv
skid_buffer.sv
axi_wr_request_channel.sv
axi_wr_response_channel.sv
apb_wr_regs.sv
axi_wr_master.sv
axi_wr_checker.sv
tb_axi_wr_master.sv

//--- skid_buffer.sv
// Two-entry valid/ready buffer; s_ready comes straight from a flop, and payload flops have no reset
`timescale 1ns/100ps

module skid_buffer #(
    parameter int word_width = 2
) (
    input  logic                  clock,
    input  logic                  rst_n,

    // Upstream side
    input  logic                  s_valid,
    output logic                  s_ready,
    input  logic [word_width-1:0] s_data,

    // Downstream side
    output logic                  m_valid,
    input  logic                  m_ready,
    output logic [word_width-1:0] m_data
);

    // Main entry drives the output, skid entry catches a word that
    // arrives while the main entry is stalled
    logic                  main_valid;
    logic [word_width-1:0] main_data;
    logic                  skid_valid;
    logic [word_width-1:0] skid_data;

    logic                  in_fire;
    logic                  main_load;

    // --------------------
    // Handshake terms

    // Room exists while the skid entry is empty, so ready is a flop output
    assign s_ready   = ~skid_valid;
    assign in_fire   = s_valid & s_ready;

    // The main entry can take a new word when it is empty or draining
    assign main_load = ~main_valid | m_ready;

    assign m_valid   = main_valid;
    assign m_data    = main_data;

    // --------------------
    // Occupancy

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_load) begin
            // The skid word moves up first, else the incoming word goes straight in
            main_valid <= skid_valid | in_fire;
            skid_valid <= 1'b0;
        end else if (in_fire) begin
            // Output is stalled, so park the new word in the skid entry
            skid_valid <= 1'b1;
        end
    end

    // --------------------
    // Payload

    always_ff @(posedge clock) begin
        if (main_load) begin
            main_data <= skid_valid ? skid_data : s_data;
        end
        // skid only captures when main is held full
        if (!main_load && in_fire) begin
            skid_data <= s_data;
        end
    end

endmodule

//--- tb_axi_wr_master.sv
// Testbench top; all stimulus follows from one xorshift seed, and every wait gives up after a bound
`timescale 1ns/100ps

module tb_axi_wr_master;

    import axi_wr_pkg::*;

    localparam int apb_limit  = 16;
    localparam int poll_limit = 200;

    logic                  clock;
    logic                  rst_n;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [apb_addr_w-1:0] paddr;
    logic [data_w-1:0]     pwdata;
    logic [data_w-1:0]     prdata;
    logic                  pready;
    logic                  pslverr;
    axi_aw_t               aw;
    logic                  awvalid;
    axi_w_t                w;
    logic                  wvalid;
    logic                  bready;

    // Slave outputs start low and are owned by the slave model below
    logic                  awready = 1'b0;
    logic                  wready = 1'b0;
    logic                  bvalid = 1'b0;
    bresp_t                bresp = okay;

    // Slave stream uses the same seed with the upper half inverted
    logic [31:0]           slave_rng = 32'hd807 ^ 32'hffff_0000;
    logic [31:0]           stim_rng;
    logic                  aw_got = 1'b0;
    logic                  w_got = 1'b0;
    logic [2:0]            b_delay = 3'd0;

    logic                  test_end;
    int                    test_num;
    int                    tests_run;
    int                    tests_failed;
    int                    errors;
    logic                  timed_out;
    logic [data_w-1:0]     rd_data;

    axi_wr_master dut (.*);

    axi_wr_checker u_check (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_stim();
        stim_rng = xorshift(stim_rng);
        return stim_rng;
    endfunction

    // --------------------
    // APB master

    // Setup phase, then access phase held until pready is seen at an edge
    task automatic apb_access(input logic wr, input logic [apb_addr_w-1:0] a,
                              input logic [data_w-1:0] d, output logic [data_w-1:0] rd);
        int n;
        rd = '0;
        if (!timed_out) begin
            psel   <= 1'b1;
            pwrite <= wr;
            paddr  <= a;
            pwdata <= d;
            @(posedge clock);
            penable <= 1'b1;
            n = 0;
            do begin
                @(posedge clock);
                n++;
            end while (!pready && n < apb_limit);
            rd = prdata;
            if (!pready) begin
                $display("Timeout: APB access to offset %h got no pready", a);
                timed_out = 1'b1;
            end
            psel    <= 1'b0;
            penable <= 1'b0;
        end
    endtask

    task automatic apb_write(input logic [apb_addr_w-1:0] a, input logic [data_w-1:0] d);
        logic [data_w-1:0] unused_rd;
        apb_access(1'b1, a, d, unused_rd);
    endtask

    task automatic apb_read(input logic [apb_addr_w-1:0] a, output logic [data_w-1:0] rd);
        apb_access(1'b0, a, '0, rd);
    endtask

    // Random command into ADDR, DATA and the CTRL strobe, with or without start
    task automatic program_write(input logic start_bit);
        logic [31:0] r;
        apb_write(reg_addr, next_stim());
        apb_write(reg_data, next_stim());
        r = next_stim();
        apb_write(reg_ctrl, {24'h0, r[3:0], 3'b000, start_bit});
    endtask

    // Poll STATUS until busy is low and done is high
    task automatic wait_write_done();
        logic [data_w-1:0] st;
        int n;
        n  = 0;
        st = '0;
        do begin
            apb_read(reg_status, st);
            n++;
        end while ((st[0] || !st[1]) && n < poll_limit && !timed_out);
        if (!timed_out && (st[0] || !st[1])) begin
            $display("Timeout: STATUS never showed the write as done");
            timed_out = 1'b1;
        end
    endtask

    // The checker prints the test line at the edge where test_end is high
    task automatic finish_test();
        if (!timed_out) begin
            test_end <= 1'b1;
            @(posedge clock);
            test_end <= 1'b0;
        end
    endtask

    // --------------------
    // AXI slave with random stalls, B follows both handshakes after a random delay

    always @(posedge clock) begin
        if (!rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= okay;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            b_delay <= 3'd0;
        end else begin
            slave_rng <= xorshift(slave_rng);
            // Ready is high about three cycles in four
            awready <= |slave_rng[1:0];
            wready  <= |slave_rng[3:2];
            if (awvalid && awready) begin
                aw_got <= 1'b1;
            end
            if (wvalid && wready) begin
                w_got <= 1'b1;
            end
            if (bvalid) begin
                if (bready) begin
                    bvalid <= 1'b0;
                    aw_got <= 1'b0;
                    w_got  <= 1'b0;
                end
            end else if (aw_got && w_got) begin
                if (b_delay == 3'd0) begin
                    bvalid <= 1'b1;
                    bresp  <= bresp_t'(slave_rng[9:8]);
                end else begin
                    b_delay <= b_delay - 3'd1;
                end
            end else begin
                b_delay <= slave_rng[6:4];
            end
        end
    end

    // --------------------
    // Test sequence

    initial begin
        logic [31:0] r;
        rst_n     = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        test_end  = 1'b0;
        test_num  = 0;
        timed_out = 1'b0;
        stim_rng  = 32'hd807;
        rd_data   = '0;
        repeat (3) @(posedge clock);
        rst_n <= 1'b1;
        @(posedge clock);

        test_num <= 1;
        apb_read(reg_status, rd_data);
        apb_read(reg_addr, rd_data);
        apb_read(reg_data, rd_data);
        apb_read(reg_ctrl, rd_data);
        finish_test();

        test_num <= 2;
        repeat (8) begin
            program_write(1'b0);
            apb_read(reg_addr, rd_data);
            apb_read(reg_data, rd_data);
            apb_read(reg_ctrl, rd_data);
        end
        finish_test();

        // CTRL is read right after start, so the start bit must read back as zero
        test_num <= 3;
        program_write(1'b1);
        apb_read(reg_ctrl, rd_data);
        wait_write_done();
        finish_test();

        test_num <= 4;
        repeat (12) begin
            program_write(1'b1);
            wait_write_done();
        end
        finish_test();

        // Second start lands while both channels are still busy
        test_num <= 5;
        program_write(1'b1);
        apb_write(reg_ctrl, 32'h0000_00f1);
        wait_write_done();
        apb_read(reg_status, rd_data);
        finish_test();

        test_num <= 6;
        repeat (6) begin
            r = next_stim();
            apb_write({r[3:2], r[1:0] | 2'b01}, next_stim());
            apb_read({r[3:2], r[1:0] | 2'b01}, rd_data);
        end
        apb_read(reg_addr, rd_data);
        apb_read(reg_data, rd_data);
        apb_read(reg_ctrl, rd_data);
        apb_read(reg_status, rd_data);
        finish_test();

        // The checker's work at the last test_end edge is complete half a cycle later
        @(negedge clock);
        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (timed_out || errors != 0) begin
            $display("Simulation failed");
        end else begin
            $display("Simulation completed successfully");
        end
        $finish;
    end

endmodule
